/* sources.f */
src/rv32_mem_pkg.sv
src/lsu_cfg_pkg.sv
src/dbus_if.sv
src/agu.sv
src/issue_queue.sv
src/lsu_ctrl.sv
src/dmem_lane_steer.sv
src/dmem_model.sv
src/lsu_top.sv
verification/tb_clock_gen.sv
verification/lsu_asserts.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - src/rv32_mem_pkg.sv
      - src/lsu_cfg_pkg.sv
      - src/dbus_if.sv
      - src/agu.sv
      - src/issue_queue.sv
      - src/lsu_ctrl.sv
      - src/dmem_lane_steer.sv
      - src/dmem_model.sv
      - src/lsu_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/lsu_asserts.sv
      - verification/lsu_tb.sv

/* verification/lsu_tb.sv */
`default_nettype none

module lsu_tb
  import rv32_mem_pkg::*;
  import lsu_cfg_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic                  is_load;
    logic                  flush_before; // pulse flush before this op issues
    logic [2:0]            group;
    word_t                 base;
    word_t                 offset;
    word_t                 sdata;
    mem_size_t             size;
    logic [4:0]            rd;
    logic [CB_INDEX_W-1:0] index;
    word_t                 exp_data;
    logic                  exp_mal;
  } op_t;

  localparam int MEM_BYTES = MEM_WORDS * 4;

  logic CLK, nRST, flush, issue_valid, issue_is_load, issue_is_store;
  word_t issue_base, issue_offset, issue_store_data, done_data;
  mem_size_t issue_size;
  logic [4:0] issue_rd, done_rd;
  logic [CB_INDEX_W-1:0] issue_index, done_index;
  logic credit_return, done_valid, done_wen, done_mal_addr;

  op_t ops [$];          // stimulus and expected values
  int expq [$];          // table rows issued but not yet completed
  logic [7:0] ref_mem [MEM_BYTES]; // byte-wide reference memory
  mem_size_t sizes [5] = '{LB, LH, LW, LBU, LHU};
  string test_names [6] = '{"load extension", "partial store merge", "misaligned access",
                            "back-to-back issue", "flush mid-burst", "random burst"};
  integer seed = 32'h44c5_aaf4;
  int issued = 0, returned = 0, done_cnt = 0, dropped = 0; // credit and completion counts
  int err_count = 0, checks = 0, tests_run = 0, tests_failed = 0, errs_at_start = 0;
  logic [2:0] cur_group;
  logic pend_flush = 1'b0;
  logic [CB_INDEX_W-1:0] next_index = '0;

  tb_clock_gen u_clk_gen (.CLK, .nRST);

  lsu_top #(.ISSUE_DEPTH(ISSUE_DEPTH), .CB_INDEX_W(CB_INDEX_W), .MEM_WORDS(MEM_WORDS),
            .WAIT_STATES(WAIT_STATES)) u_lsu_top (.*);

  bind lsu_ctrl lsu_asserts u_lsu_asserts (
    .CLK, .nRST, .flush, .ren(bus.ren), .wen(bus.wen), .busy(bus.busy), .addr(bus.addr),
    .wdata(bus.wdata), .byte_en(bus.byte_en), .credit_return, .q_pop
  );

  function automatic int total_errors();
    return err_count + u_lsu_top.u_lsu_ctrl.u_lsu_asserts.fail_count;
  endfunction

  task automatic check(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH %s: got %h expected %h", what, got, exp);
    end
  endtask

  // append one op, expected result taken from the byte model in program order
  task automatic add_op(input logic ld, input word_t base, input word_t off,
                        input mem_size_t sz, input word_t sdata);
    op_t   op;
    word_t ea;
    word_t v;
    int    n;
    ea = base + off;
    case (sz)
      LB, LBU: n = 1;
      LH, LHU: n = 2;
      default: n = 4;
    endcase
    op = '0;
    op.is_load = ld;
    op.flush_before = pend_flush;
    op.group = cur_group;
    op.base = base;
    op.offset = off;
    op.sdata = sdata;
    op.size = sz;
    op.rd = 5'(ops.size() % 31 + 1);
    op.index = next_index;
    op.exp_mal = (n == 2 && ea[0]) || (n == 4 && ea[1:0] != 2'b00);
    v = '0;
    if (!op.exp_mal) begin
      for (int k = 0; k < n; k++) begin // little endian, lowest byte first
        if (ld) v[8*k +: 8] = ref_mem[(ea + k) % MEM_BYTES];
        else ref_mem[(ea + k) % MEM_BYTES] = sdata[8*k +: 8];
      end
    end
    if (sz == LB) v = {{24{v[7]}}, v[7:0]};
    if (sz == LH) v = {{16{v[15]}}, v[15:0]};
    op.exp_data = v; // unsigned sizes are already zero above n bytes
    ops.push_back(op);
    next_index++;
    pend_flush = 1'b0;
  endtask

  task automatic build_table();
    word_t r;
    mem_size_t sz;
    word_t off;
    foreach (ref_mem[i]) ref_mem[i] = 8'h00; // ram is zero after reset
    cur_group = 1;
    add_op(0, 32'h100, 0, LW, 32'h8a7b_f6e5);
    add_op(0, 32'h10a, 32'hffff_fffc, LH, 32'h0000_9c31); // negative offset, lands on 0x106
    add_op(0, 32'h104, 0, LB, 32'h0000_0085);
    add_op(0, 32'h104, 1, LB, 32'h0000_0042);
    for (int a = 0; a < 8; a++) begin // every lane of both words
      add_op(1, 32'h100, a, LB, 0);
      add_op(1, 32'h100, a, LBU, 0);
      if (a % 2 == 0) add_op(1, 32'h100, a, LH, 0);
      if (a % 2 == 0) add_op(1, 32'h100, a, LHU, 0);
      if (a % 4 == 0) add_op(1, 32'h100, a, LW, 0);
    end
    cur_group = 2;
    add_op(0, 32'h200, 0, LW, 32'h1122_3344);
    add_op(0, 32'h200, 1, LB, 32'h0000_00aa);
    add_op(0, 32'h200, 2, LH, 32'h0000_beef);
    add_op(1, 32'h200, 0, LW, 0); // merged word
    add_op(0, 32'h200, 3, LB, 32'h0000_007f);
    add_op(1, 32'h200, 0, LW, 0);
    cur_group = 3;
    add_op(0, 32'h300, 0, LW, 32'hcafe_f00d);
    add_op(0, 32'h300, 1, LH, 32'h0000_1234); // odd half
    add_op(0, 32'h300, 2, LW, 32'h5555_aaaa); // word on a half boundary
    add_op(1, 32'h300, 3, LH, 0);
    add_op(1, 32'h300, 1, LW, 0);
    add_op(1, 32'h300, 0, LW, 0); // must still read cafef00d
    cur_group = 4;
    for (int k = 0; k < ISSUE_DEPTH; k++) begin
      add_op(k % 2, 32'h400, (k / 2) * 4, LW, 32'h0101_0101 * (k + 1));
    end
    cur_group = 5;
    for (int k = 0; k < ISSUE_DEPTH; k++) add_op(1, 32'h100, 4 * (k % 2), LW, 0);
    pend_flush = 1'b1; // loads only ahead of the flush, memory stays known
    add_op(1, 32'h200, 0, LW, 0);
    add_op(0, 32'h208, 0, LH, 32'h7777_8001);
    add_op(1, 32'h208, 0, LH, 0);
    cur_group = 6;
    for (int k = 0; k < 24; k++) begin
      r   = $random(seed);
      sz  = sizes[r[10:8] % (r[0] ? 5 : 3)]; // stores only LB, LH, LW
      off = {26'b0, r[21:16]};
      if (sz == LW) off[1:0] = 2'b00;
      if (sz == LH || sz == LHU) off[0] = 1'b0;
      add_op(r[0], 32'h500, off, sz, $random(seed));
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    dropped += expq.size(); // everything in flight is gone
    expq.delete();
    issued = returned; // credits back to ISSUE_DEPTH
  endtask

  task automatic finish_test(input logic [2:0] grp);
    int errs;
    while (expq.size() != 0) next_cycle();
    errs = total_errors() - errs_at_start;
    $display("test %0d %s: %s, %0d errors", grp, test_names[grp - 1],
             (errs == 0) ? "ok" : "FAILED", errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    errs_at_start = total_errors();
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge CLK);
    $display("timeout after %0d cycles, completions stopped arriving", cycles);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic compare_done(input op_t op);
    check("done_index", done_index, op.index);
    check("done_rd", done_rd, op.rd);
    check("done_mal_addr", done_mal_addr, op.exp_mal);
    check("done_wen", done_wen, op.is_load && !op.exp_mal);
    if (op.is_load && !op.exp_mal) check("done_data", done_data, op.exp_data);
  endtask

  // completions in issue order, sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST && credit_return) returned++;
    if (nRST && done_valid) begin
      done_cnt++;
      if (expq.size() == 0) begin
        err_count++;
        $display("completion for index %h arrived with no operation outstanding", done_index);
      end else begin
        compare_done(ops[expq.pop_front()]);
      end
    end
  end

  initial begin
    flush = 1'b0;
    issue_valid = 1'b0;
    issue_is_load = 1'b0;
    issue_is_store = 1'b0;
    issue_base = '0;
    issue_offset = '0;
    issue_store_data = '0;
    issue_size = LB;
    issue_rd = '0;
    issue_index = '0;
    build_table();
    fork
      watchdog(ops.size() * (WAIT_STATES + 4) + 200);
    join_none
    @(posedge nRST);
    next_cycle();
    for (int i = 0; i < ops.size(); i++) begin
      if (ops[i].flush_before) pulse_flush();
      while (issued - returned >= ISSUE_DEPTH) next_cycle(); // out of credits
      issue_valid      = 1'b1;
      issue_is_load    = ops[i].is_load;
      issue_is_store   = !ops[i].is_load;
      issue_base       = ops[i].base;
      issue_offset     = ops[i].offset;
      issue_store_data = ops[i].sdata;
      issue_size       = ops[i].size;
      issue_rd         = ops[i].rd;
      issue_index      = ops[i].index;
      issued++;
      expq.push_back(i);
      next_cycle();
      issue_valid = 1'b0;
      if (i == ops.size() - 1 || ops[i + 1].group != ops[i].group) finish_test(ops[i].group);
    end
    check("credit_return pulses", returned, ops.size() - dropped);
    check("completions", done_cnt, ops.size() - dropped);
    $display("totals: %0d tests, %0d failed, %0d checks, %0d errors, %0d ops flushed",
             tests_run, tests_failed, checks, total_errors(), dropped);
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/lsu_asserts.sv */
`default_nettype none

module lsu_asserts
  import rv32_mem_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       ren,
  input  logic       wen,
  input  logic       busy,
  input  word_t      addr,
  input  word_t      wdata,
  input  logic [3:0] byte_en,
  input  logic       credit_return,
  input  logic       q_pop
);
  timeunit 1ns;
  timeprecision 100ps;

  int         fail_count = 0; // failed assertions so far
  logic [1:0] owed;           // popped ops still waiting for their credit

  // pops minus credits, a flush forgets everything in flight
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      owed <= '0;
    end else if (flush) begin
      owed <= '0; // flushed ops give no credit back
    end else if (q_pop && !credit_return) begin
      owed <= owed + 1'b1;
    end else if (credit_return && !q_pop) begin
      owed <= owed - 1'b1;
    end
  end

  // a waiting request may not move, a flush abandons it instead
  req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (busy && !flush) |=> ($stable(ren) && $stable(wen) && $stable(addr)
                          && $stable(wdata) && $stable(byte_en)))
    else begin $error("bus request changed while busy"); fail_count++; end

  credit_match: assert property (@(posedge CLK) disable iff (!nRST)
    credit_return |-> (owed == 2'd1)) // exactly one credit per popped op
    else begin $error("credit_return without exactly one popped op"); fail_count++; end

  no_pop_busy: assert property (@(posedge CLK) disable iff (!nRST)
    q_pop |-> (owed == 2'd0)) // previous op has not completed yet
    else begin $error("queue popped into a full latch"); fail_count++; end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2, // ns, 4 ns clock
  parameter int RESET_CYCLES = 8
) (
  output logic CLK,
  output logic nRST
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1; // release just after the edge
  end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`default_nettype none

module lsu_top
  import lsu_cfg_pkg::*;
  import rv32_mem_pkg::*;
#(
  parameter int ISSUE_DEPTH = lsu_cfg_pkg::ISSUE_DEPTH,
  parameter int CB_INDEX_W  = lsu_cfg_pkg::CB_INDEX_W,
  parameter int MEM_WORDS   = lsu_cfg_pkg::MEM_WORDS,
  parameter int WAIT_STATES = lsu_cfg_pkg::WAIT_STATES
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  issue_valid,
  input  logic                  issue_is_load,
  input  logic                  issue_is_store,
  input  word_t                 issue_base,
  input  word_t                 issue_offset,
  input  word_t                 issue_store_data,
  input  mem_size_t             issue_size,
  input  logic [4:0]            issue_rd,
  input  logic [CB_INDEX_W-1:0] issue_index,
  output logic                  credit_return,
  output logic                  done_valid,
  output logic [CB_INDEX_W-1:0] done_index,
  output logic [4:0]            done_rd,
  output logic                  done_wen,
  output word_t                 done_data,
  output logic                  done_mal_addr
);

  issue_entry_t issue_entry, q_head;
  logic         q_empty, q_pop;
  word_t        agu_addr, load_word, bus_wdata, lat_store_data;
  logic [3:0]   agu_byte_en, lat_byte_en;
  logic         agu_mal;
  mem_size_t    lat_size;

  dbus_if dbus ();

  // pack the flat issue port into one queue entry
  assign issue_entry = '{
    is_load:    issue_is_load,
    is_store:   issue_is_store,
    base:       issue_base,
    offset:     issue_offset,
    store_data: issue_store_data,
    size:       issue_size,
    rd:         issue_rd,
    index:      issue_index
  };

  issue_queue #(.DEPTH(ISSUE_DEPTH)) u_issue_queue (
    .CLK, .nRST, .flush,
    .push(issue_valid), .push_entry(issue_entry), .pop(q_pop),
    .head(q_head), .empty(q_empty)
  );

  // address of the queue head, latched on pop
  agu u_agu (
    .base(q_head.base), .offset(q_head.offset), .size(q_head.size),
    .addr(agu_addr), .byte_en(agu_byte_en), .mal_addr(agu_mal)
  );

  lsu_ctrl #(.CB_INDEX_W(CB_INDEX_W)) u_lsu_ctrl (
    .CLK, .nRST, .flush, .q_empty, .q_head, .agu_addr, .agu_byte_en, .agu_mal,
    .load_word, .q_pop, .credit_return, .done_valid, .done_index, .done_rd,
    .done_wen, .done_data, .done_mal_addr, .lat_size, .lat_store_data,
    .lat_byte_en, .bus(dbus.cpu), .bus_wdata
  );

  dmem_lane_steer u_lane_steer (
    .size(lat_size), .byte_en(lat_byte_en), .store_data(lat_store_data),
    .rdata(dbus.rdata), .wdata(bus_wdata), .load_word(load_word)
  );

  dmem_model #(.MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES)) u_dmem (
    .CLK, .nRST, .flush, .bus(dbus.mem)
  );

endmodule

`default_nettype wire

/* src/dmem_model.sv */
`default_nettype none

module dmem_model
  import rv32_mem_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic flush,
  dbus_if.mem  bus
);

  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  word_t         ram [MEM_WORDS];
  logic [AW-1:0] widx;     // word index, byte offset dropped
  logic [CW-1:0] wait_cnt; // wait cycles spent on this request
  logic          req;
  logic          done;     // request present with busy low

  assign req  = bus.ren || bus.wen;
  assign widx = bus.addr[AW+1:2]; // upper address bits ignored
  assign bus.busy  = req && (wait_cnt != CW'(WAIT_STATES));
  assign done      = req && !bus.busy;
  assign bus.rdata = ram[widx]; // sampled by the lsu on the done cycle

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (flush || !req || done) begin
      wait_cnt <= '0; // restart for the next request
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // ram clears on reset, writes land on the completing cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (done && bus.wen && !flush) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.byte_en[b]) ram[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* src/dmem_lane_steer.sv */
`default_nettype none

module dmem_lane_steer
  import rv32_mem_pkg::*;
(
  input  mem_size_t  size,
  input  logic [3:0] byte_en,
  input  word_t      store_data,
  input  word_t      rdata,
  output word_t      wdata,
  output word_t      load_word
);

  logic [7:0]  byte_sel; // enabled byte of the read word
  logic [15:0] half_sel; // enabled half of the read word

  // store side, the byte enables pick the lane in memory
  always_comb begin
    wdata = store_data;
    if (is_byte_size(size)) begin
      wdata = {4{store_data[7:0]}};
    end else if (is_half_size(size)) begin
      wdata = {2{store_data[15:0]}};
    end
  end

  always_comb begin
    case (byte_en)
      4'b0010: byte_sel = rdata[15:8];
      4'b0100: byte_sel = rdata[23:16];
      4'b1000: byte_sel = rdata[31:24];
      default: byte_sel = rdata[7:0];
    endcase
  end

  assign half_sel = byte_en[2] ? rdata[31:16] : rdata[15:0];

  // extension by size
  always_comb begin
    load_word = rdata; // LW passes straight through
    if (is_byte_size(size)) begin
      load_word = is_unsigned_size(size) ? {24'b0, byte_sel}
                                         : {{24{byte_sel[7]}}, byte_sel};
    end else if (is_half_size(size)) begin
      load_word = is_unsigned_size(size) ? {16'b0, half_sel}
                                         : {{16{half_sel[15]}}, half_sel};
    end
  end

endmodule

`default_nettype wire

/* src/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl
  import lsu_cfg_pkg::*;
  import rv32_mem_pkg::*;
#(
  parameter int CB_INDEX_W = lsu_cfg_pkg::CB_INDEX_W
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  q_empty,
  input  issue_entry_t          q_head,
  input  word_t                 agu_addr,
  input  logic [3:0]            agu_byte_en,
  input  logic                  agu_mal,
  input  word_t                 load_word,
  output logic                  q_pop,
  output logic                  credit_return,
  output logic                  done_valid,
  output logic [CB_INDEX_W-1:0] done_index,
  output logic [4:0]            done_rd,
  output logic                  done_wen,
  output word_t                 done_data,
  output logic                  done_mal_addr,
  output mem_size_t             lat_size,
  output word_t                 lat_store_data,
  output logic [3:0]            lat_byte_en,
  dbus_if.cpu                   bus,
  input  word_t                 bus_wdata
);

  // memory latch, one op in flight on the bus
  logic                  lat_valid;
  logic                  lat_is_load, lat_is_store;
  logic                  lat_mal;
  word_t                 lat_addr;
  logic [4:0]            lat_rd;
  logic [CB_INDEX_W-1:0] lat_index;
  logic                  lat_ok; // aligned, so it goes out on the bus

  assign lat_ok = lat_valid && !lat_mal;

  // take the head only into a free latch
  assign q_pop = !lat_valid && !q_empty && !flush;

  // misaligned ops finish at once, the rest wait for busy to drop
  assign done_valid    = lat_valid && !flush && (lat_mal || !bus.busy);
  assign credit_return = done_valid; // one credit per finished op

  assign done_index    = lat_index;
  assign done_rd       = lat_rd;
  assign done_wen      = lat_is_load && !lat_mal; // a faulting load writes nothing
  assign done_data     = done_wen ? load_word : '0;
  assign done_mal_addr = lat_mal;

  // request masked by misalignment, held stable by the latch
  assign bus.ren     = lat_ok && lat_is_load;
  assign bus.wen     = lat_ok && lat_is_store;
  assign bus.addr    = lat_addr;
  assign bus.wdata   = bus_wdata;
  assign bus.byte_en = lat_byte_en;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_valid <= 1'b0;
    end else if (flush) begin
      lat_valid <= 1'b0; // abandon whatever is in flight
    end else if (q_pop) begin
      lat_valid <= 1'b1;
    end else if (done_valid) begin
      lat_valid <= 1'b0;
    end
  end

  // payload, agu results registered with the head
  always_ff @(posedge CLK) begin
    if (q_pop) begin
      lat_is_load    <= q_head.is_load;
      lat_is_store   <= q_head.is_store;
      lat_addr       <= agu_addr;
      lat_byte_en    <= agu_byte_en;
      lat_mal        <= agu_mal;
      lat_size       <= q_head.size;
      lat_store_data <= q_head.store_data;
      lat_rd         <= q_head.rd;
      lat_index      <= q_head.index;
    end
  end

endmodule

`default_nettype wire

/* src/issue_queue.sv */
`default_nettype none

module issue_queue
  import lsu_cfg_pkg::*;
#(
  parameter int DEPTH = ISSUE_DEPTH
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         flush,
  input  logic         push,
  input  issue_entry_t push_entry,
  input  logic         pop,
  output issue_entry_t head,
  output logic         empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  issue_entry_t slots [DEPTH]; // payload only, no reset
  logic [PW-1:0] rd_ptr, wr_ptr;
  logic [CW-1:0] count;

  // pointer step with explicit wrap so DEPTH need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head  = slots[rd_ptr];
  assign empty = (count == '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0; // drop everything queued
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // credits keep push away from a full queue
  always_ff @(posedge CLK) begin
    if (push && !flush) slots[wr_ptr] <= push_entry;
  end

endmodule

`default_nettype wire

/* src/agu.sv */
`default_nettype none

module agu
  import rv32_mem_pkg::*;
(
  input  word_t      base,
  input  word_t      offset,
  input  mem_size_t  size,
  output word_t      addr,
  output logic [3:0] byte_en,
  output logic       mal_addr
);

  logic [1:0] lo; // byte offset inside the word

  assign addr = base + offset; // wraps like the core's adder
  assign lo   = addr[1:0];

  // little-endian lanes: byte 0 lives in bits 7:0
  always_comb begin
    byte_en = 4'b1111;
    if (is_byte_size(size)) begin
      byte_en = 4'b0001 << lo;
    end else if (is_half_size(size)) begin
      byte_en = lo[1] ? 4'b1100 : 4'b0011; // upper or lower half
    end
  end

  // halves need an even address, words need both low bits clear
  always_comb begin
    mal_addr = 1'b0;
    if (is_half_size(size)) begin
      mal_addr = lo[0];
    end else if (size == LW) begin
      mal_addr = |lo;
    end
  end

endmodule

`default_nettype wire

/* src/dbus_if.sv */
`default_nettype none

interface dbus_if
  import rv32_mem_pkg::*;
;

  logic       ren;     // read request
  logic       wen;     // write request
  word_t      addr;    // byte address
  word_t      wdata;   // lane-replicated store data
  logic [3:0] byte_en; // little-endian lane enables
  word_t      rdata;   // whole word, lanes not shifted
  logic       busy;    // wait state, request must stay stable

  // lsu side
  modport cpu (
    output ren, wen, addr, wdata, byte_en,
    input  rdata, busy
  );

  // memory side
  modport mem (
    input  ren, wen, addr, wdata, byte_en,
    output rdata, busy
  );

endinterface

`default_nettype wire

/* src/lsu_cfg_pkg.sv */
`default_nettype none

package lsu_cfg_pkg;

  import rv32_mem_pkg::*;

  // default configuration, the top level passes these down as parameters
  localparam int ISSUE_DEPTH = 4;  // queue slots == issuer credits
  localparam int CB_INDEX_W  = 3;  // completion buffer index width
  localparam int MEM_WORDS   = 256; // ram size in words
  localparam int WAIT_STATES = 2;  // busy cycles per access

  // one memory op as handed over by the issue side
  typedef struct packed {
    logic                  is_load;
    logic                  is_store;
    word_t                 base;       // rs1 value
    word_t                 offset;     // sign extended immediate
    word_t                 store_data; // rs2 value, unshifted
    mem_size_t             size;
    logic [4:0]            rd;         // load destination
    logic [CB_INDEX_W-1:0] index;      // completion buffer slot
  } issue_entry_t;

endpackage

`default_nettype wire

/* src/rv32_mem_pkg.sv */
`default_nettype none

package rv32_mem_pkg;

  // one data word on the bus and in the datapath
  typedef logic [31:0] word_t;

  // access size; codes follow funct3 of the rv32i load/store encodings
  // stores reuse LB, LH and LW for byte, half and word
  typedef enum logic [2:0] {
    LB  = 3'b000, // signed byte
    LH  = 3'b001, // signed half
    LW  = 3'b010, // full word
    LBU = 3'b100, // unsigned byte
    LHU = 3'b101  // unsigned half
  } mem_size_t;

  // byte and half helpers, shared by the agu and lane steering
  function automatic logic is_byte_size(input mem_size_t size);
    return (size == LB) || (size == LBU);
  endfunction

  function automatic logic is_half_size(input mem_size_t size);
    return (size == LH) || (size == LHU);
  endfunction

  // unsigned variants zero extend, the rest sign extend
  function automatic logic is_unsigned_size(input mem_size_t size);
    return (size == LBU) || (size == LHU);
  endfunction

endpackage

`default_nettype wire
